// File: log_interconnect.f
src/lic_pkg.sv
src/addr_dec_req.sv
src/rr_arb_tree.sv
src/tcdm_bank.sv
src/resp_router.sv
src/log_interconnect.sv
verif/log_interconnect_checker.sv
verif/tb_log_interconnect.sv

// File: verif/tb_log_interconnect.sv
// Directed and random testbench for the interconnect against a reference memory model

`default_nettype none

module tb_log_interconnect;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAND_CYCLES = 300;
    // Reset, four directed tests, random traffic and its drain
    localparam int TEST_CYCLES = 4 + 4 + 4 + 10 + 5 + RAND_CYCLES + 6;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;
    localparam int MEM_WORDS = 2 ** lic_pkg::ADDR_W;

    logic                                       clk;
    logic                                       rst_i;
    logic [lic_pkg::N_MASTER-1:0]               data_req_i;
    lic_pkg::lic_req_t [lic_pkg::N_MASTER-1:0]  data_i;
    logic [lic_pkg::N_MASTER-1:0]               data_gnt_o;
    lic_pkg::lic_resp_t [lic_pkg::N_MASTER-1:0] resp_o;

    //////////////////////////////
    // Reference model state
    //////////////////////////////

    // Flat memory indexed by master word address
    logic [lic_pkg::DATA_W-1:0]                 ref_mem [MEM_WORDS];
    bit                                         ref_known [MEM_WORDS];
    // Round-robin pointer per bank
    int                                         ref_ptr [lic_pkg::N_BANK];
    // Responses owed in the next cycle
    lic_pkg::lic_resp_t [lic_pkg::N_MASTER-1:0] exp_resp;
    bit                                         exp_known [lic_pkg::N_MASTER];

    logic [31:0] lfsr_q;
    int          cycle_cnt = 0;
    int          gnt_errs;
    int          resp_errs;

    log_interconnect UUT
    (
        .clk        (clk),
        .rst_i      (rst_i),
        .data_req_i (data_req_i),
        .data_i     (data_i),
        .data_gnt_o (data_gnt_o),
        .resp_o     (resp_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Watchdog on total run length
    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors: grant %0d, response %0d, assertion %0d",
                     gnt_errs, resp_errs, UUT.u_checker.fail_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    function automatic lic_pkg::lic_req_t build_req(input int addr, input lic_pkg::lic_op_e op,
                                                   input logic [lic_pkg::DATA_W-1:0] wdata);
        lic_pkg::lic_req_t r;
        r.addr  = lic_pkg::ADDR_W'(addr);
        r.op    = op;
        r.wdata = wdata;
        return r;
    endfunction

    // Round robin per bank, scanning from the tracked pointer
    function automatic logic [lic_pkg::N_MASTER-1:0] predict_gnt(
        input logic [lic_pkg::N_MASTER-1:0] req,
        input lic_pkg::lic_req_t [lic_pkg::N_MASTER-1:0] d);
        logic [lic_pkg::N_MASTER-1:0] g;
        bit found;
        int m;
        g = '0;
        for (int b = 0; b < lic_pkg::N_BANK; b++)
        begin
            found = 1'b0;
            for (int k = 0; k < lic_pkg::N_MASTER; k++)
            begin
                m = (ref_ptr[b] + k) % lic_pkg::N_MASTER;
                if (!found && req[m] && (int'(d[m].addr) % lic_pkg::N_BANK == b))
                begin
                    found = 1'b1;
                    g[m] = 1'b1;
                end
            end
        end
        return g;
    endfunction

    task automatic compare_gnt(input logic [lic_pkg::N_MASTER-1:0] exp_gnt,
                               input logic [lic_pkg::N_MASTER-1:0] act_gnt, input string what);
        if (act_gnt !== exp_gnt)
        begin
            gnt_errs++;
            $display("MISMATCH at %0t ns: %s grant expected %b, got %b",
                     $time, what, exp_gnt, act_gnt);
        end
    endtask

    task automatic compare_resp(input int m, input lic_pkg::lic_resp_t exp_r,
                                input lic_pkg::lic_resp_t act_r, input bit check_data);
        if (act_r.valid !== exp_r.valid)
        begin
            resp_errs++;
            $display("MISMATCH at %0t ns: master %0d response valid expected %b, got %b",
                     $time, m, exp_r.valid, act_r.valid);
        end
        else if (exp_r.valid && check_data && (act_r.rdata !== exp_r.rdata))
        begin
            resp_errs++;
            $display("MISMATCH at %0t ns: master %0d read data expected %h, got %h",
                     $time, m, exp_r.rdata, act_r.rdata);
        end
    endtask

    // One clock of traffic: drive, check owed responses and grants, update the model
    task automatic step(input logic [lic_pkg::N_MASTER-1:0] req,
                        input lic_pkg::lic_req_t [lic_pkg::N_MASTER-1:0] d,
                        output logic [lic_pkg::N_MASTER-1:0] gnt);
        logic [lic_pkg::N_MASTER-1:0] exp_gnt;
        int a;
        @(posedge clk);
        data_req_i <= req;
        data_i     <= d;
        @(negedge clk);
        for (int m = 0; m < lic_pkg::N_MASTER; m++)
        begin
            compare_resp(m, exp_resp[m], resp_o[m], exp_known[m]);
        end
        exp_gnt = predict_gnt(req, d);
        compare_gnt(exp_gnt, data_gnt_o, "cycle");
        exp_resp = '0;
        for (int m = 0; m < lic_pkg::N_MASTER; m++)
        begin
            exp_known[m] = 1'b0;
            if (exp_gnt[m])
            begin
                a = int'(d[m].addr);
                ref_ptr[a % lic_pkg::N_BANK] = (m + 1) % lic_pkg::N_MASTER;
                if (d[m].op == lic_pkg::OP_WRITE)
                begin
                    ref_mem[a]   = d[m].wdata;
                    ref_known[a] = 1'b1;
                end
                else
                begin
                    exp_resp[m].valid = 1'b1;
                    exp_resp[m].rdata = ref_mem[a];
                    exp_known[m]      = ref_known[a];
                end
            end
        end
        gnt = exp_gnt;
    endtask

    // Masters hold request and payload until each one is granted
    task automatic issue(input logic [lic_pkg::N_MASTER-1:0] req,
                         input lic_pkg::lic_req_t [lic_pkg::N_MASTER-1:0] d);
        logic [lic_pkg::N_MASTER-1:0] pend;
        logic [lic_pkg::N_MASTER-1:0] g;
        pend = req;
        while (pend != '0)
        begin
            step(pend, d, g);
            pend = pend & ~g;
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic test_single_rw();
        lic_pkg::lic_req_t [lic_pkg::N_MASTER-1:0] d;
        logic [lic_pkg::N_MASTER-1:0] g;
        lic_pkg::lic_resp_t r;
        d = '0;
        d[0] = build_req(10'h025, lic_pkg::OP_WRITE, 32'hcafe_0001);
        step(4'b0001, d, g);
        compare_gnt(4'b0001, data_gnt_o, "single write");
        d[0] = build_req(10'h025, lic_pkg::OP_READ, '0);
        step(4'b0001, d, g);
        compare_gnt(4'b0001, data_gnt_o, "single read");
        step('0, d, g);
        // Read data straight against the written word
        r.valid = 1'b1;
        r.rdata = 32'hcafe_0001;
        compare_resp(0, r, resp_o[0], 1'b1);
    endtask

    task automatic test_parallel();
        lic_pkg::lic_req_t [lic_pkg::N_MASTER-1:0] d;
        logic [lic_pkg::N_MASTER-1:0] g;
        // Master m owns bank m for the writes
        for (int m = 0; m < lic_pkg::N_MASTER; m++)
        begin
            d[m] = build_req((16 + m) * 4 + m, lic_pkg::OP_WRITE, rand_bits(32));
        end
        step(4'hf, d, g);
        compare_gnt(4'hf, data_gnt_o, "parallel write");
        // Reads rotated by one bank, still all distinct
        for (int m = 0; m < lic_pkg::N_MASTER; m++)
        begin
            d[m] = build_req((17 + m) % 4 * 5 + 64, lic_pkg::OP_READ, '0);
        end
        step(4'hf, d, g);
        compare_gnt(4'hf, data_gnt_o, "parallel read");
        step('0, d, g);
    endtask

    task automatic test_conflict();
        lic_pkg::lic_req_t [lic_pkg::N_MASTER-1:0] d;
        logic [lic_pkg::N_MASTER-1:0] g;
        // Everyone targets bank 2
        for (int m = 0; m < lic_pkg::N_MASTER; m++)
        begin
            d[m] = build_req((64 + m) * 4 + 2, lic_pkg::OP_WRITE, rand_bits(32));
        end
        issue(4'hf, d);
        for (int m = 0; m < lic_pkg::N_MASTER; m++)
        begin
            d[m] = build_req((67 - m) * 4 + 2, lic_pkg::OP_READ, '0);
        end
        issue(4'hf, d);
        step('0, d, g);
    endtask

    task automatic test_hold();
        lic_pkg::lic_req_t [lic_pkg::N_MASTER-1:0] d;
        logic [lic_pkg::N_MASTER-1:0] g;
        d = '0;
        d[1] = build_req(10'h1b3, lic_pkg::OP_WRITE, 32'h1111_aaaa);
        d[3] = build_req(10'h1b3, lic_pkg::OP_WRITE, 32'h3333_cccc);
        issue(4'b1010, d);
        // Last granted writer must win
        d[0] = build_req(10'h1b3, lic_pkg::OP_READ, '0);
        step(4'b0001, d, g);
        step('0, d, g);
    endtask

    task automatic test_random();
        lic_pkg::lic_req_t [lic_pkg::N_MASTER-1:0] d;
        logic [lic_pkg::N_MASTER-1:0] pend;
        logic [lic_pkg::N_MASTER-1:0] g;
        d = '0;
        pend = '0;
        for (int c = 0; c < RAND_CYCLES; c++)
        begin
            for (int m = 0; m < lic_pkg::N_MASTER; m++)
            begin
                // Small address window keeps conflicts and read hits frequent
                if (!pend[m] && (rand_bits(1) != 0))
                begin
                    pend[m]     = 1'b1;
                    d[m].addr   = lic_pkg::ADDR_W'(rand_bits(5));
                    d[m].op     = lic_pkg::lic_op_e'(rand_bits(1));
                    d[m].wdata  = rand_bits(32);
                end
            end
            step(pend, d, g);
            pend = pend & ~g;
        end
        issue(pend, d);
        step('0, d, g);
    endtask

    initial
    begin
        rst_i      = 1'b1;
        data_req_i = '0;
        data_i     = '0;
        lfsr_q     = 32'h5fab_6845;
        gnt_errs   = 0;
        resp_errs  = 0;
        exp_resp   = '0;
        for (int b = 0; b < lic_pkg::N_BANK; b++)
        begin
            ref_ptr[b] = 0;
        end
        for (int m = 0; m < lic_pkg::N_MASTER; m++)
        begin
            exp_known[m] = 1'b0;
        end
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        test_single_rw();
        test_parallel();
        test_conflict();
        test_hold();
        test_random();
        $display("Errors: grant %0d, response %0d, assertion %0d",
                 gnt_errs, resp_errs, UUT.u_checker.fail_cnt);
        if (gnt_errs + resp_errs + UUT.u_checker.fail_cnt == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/log_interconnect_checker.sv
// Concurrent checks on grant exclusivity and read response timing of the interconnect

`default_nettype none

module log_interconnect_checker
(
    input logic                                                 clk_i,
    input logic                                                 rst_i,
    input logic [lic_pkg::N_MASTER-1:0]                         req_i,
    input logic [lic_pkg::N_MASTER-1:0]                         gnt_i,
    input logic [lic_pkg::N_BANK-1:0][lic_pkg::N_MASTER-1:0]    bank_gnt_i,
    input logic [lic_pkg::N_BANK-1:0]                           rd_gnt_i,
    input logic [lic_pkg::N_BANK-1:0][lic_pkg::MST_W-1:0]       winner_i,
    input lic_pkg::lic_resp_t [lic_pkg::N_MASTER-1:0]           resp_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // Valid bits of all responses side by side
    logic [lic_pkg::N_MASTER-1:0] resp_valid;
    // Assertion failures seen so far
    int                           fail_cnt = 0;

    always_comb
    begin
        for (int m = 0; m < lic_pkg::N_MASTER; m++)
        begin
            resp_valid[m] = resp_i[m].valid;
        end
    end

    // A master never sees a grant it did not ask for
    a_gnt_has_req: assert property (@(posedge clk_i) disable iff (rst_i)
        (gnt_i & ~req_i) == '0)
        else
        begin
            fail_cnt++;
            $error("grant without request: req %b gnt %b", req_i, gnt_i);
        end

    //////////////////////////////
    // Per bank
    //////////////////////////////

    for (genvar b = 0; b < lic_pkg::N_BANK; b++)
    begin : g_bank
        // One winner per bank at most
        a_one_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
            $onehot0(bank_gnt_i[b]))
            else
            begin
                fail_cnt++;
                $error("bank %0d granted several masters: %b", b, bank_gnt_i[b]);
            end

        // Read data lands at the winning master one cycle later
        a_rd_resp: assert property (@(posedge clk_i) disable iff (rst_i)
            rd_gnt_i[b] |=> resp_valid[$past(winner_i[b])])
            else
            begin
                fail_cnt++;
                $error("bank %0d read got no response at its master", b);
            end
    end

    // No extra responses beyond the reads granted the cycle before
    a_resp_count: assert property (@(posedge clk_i) disable iff (rst_i)
        $countones(resp_valid) == $past($countones(rd_gnt_i)))
        else
        begin
            fail_cnt++;
            $error("response count %0d does not match granted reads",
                   $countones(resp_valid));
        end

endmodule

bind log_interconnect log_interconnect_checker u_checker
(
    .clk_i      (clk),
    .rst_i      (rst_i),
    .req_i      (data_req_i),
    .gnt_i      (data_gnt_o),
    .bank_gnt_i (gnt_bm),
    .rd_gnt_i   (rd_gnt),
    .winner_i   (winner),
    .resp_i     (resp_o)
);

`default_nettype wire

// File: src/log_interconnect.sv
// Top level of the word-interleaved interconnect between four masters and four banks

`default_nettype none

module log_interconnect
(
    input  logic                                        clk,
    input  logic                                        rst_i,

    // Master request side
    input  logic [lic_pkg::N_MASTER-1:0]                data_req_i,
    input  lic_pkg::lic_req_t [lic_pkg::N_MASTER-1:0]   data_i,
    output logic [lic_pkg::N_MASTER-1:0]                data_gnt_o,

    // Master response side
    output lic_pkg::lic_resp_t [lic_pkg::N_MASTER-1:0]  resp_o
);

    // Request and grant matrices, indexed master first
    logic [lic_pkg::N_MASTER-1:0][lic_pkg::N_BANK-1:0]      req_mb;
    logic [lic_pkg::N_MASTER-1:0][lic_pkg::N_BANK-1:0]      gnt_mb;
    // Same matrices indexed bank first
    logic [lic_pkg::N_BANK-1:0][lic_pkg::N_MASTER-1:0]      req_bm;
    logic [lic_pkg::N_BANK-1:0][lic_pkg::N_MASTER-1:0]      gnt_bm;

    // Per-bank arbiter outputs
    logic [lic_pkg::N_BANK-1:0]                             bank_en;
    lic_pkg::lic_bank_req_t [lic_pkg::N_BANK-1:0]           bank_req;
    logic [lic_pkg::N_BANK-1:0][lic_pkg::MST_W-1:0]         winner;
    logic [lic_pkg::N_BANK-1:0]                             rd_gnt;
    logic [lic_pkg::N_BANK-1:0][lic_pkg::DATA_W-1:0]        bank_rdata;

    //////////////////////////////
    // Master side decoders
    //////////////////////////////

    for (genvar m = 0; m < lic_pkg::N_MASTER; m++)
    begin : g_master
        // Low word-address bits pick the bank
        addr_dec_req u_addr_dec_req
        (
            .data_req_i     (data_req_i[m]),
            .routing_addr_i (data_i[m].addr[lic_pkg::BANK_SEL_W-1:0]),
            .data_gnt_o     (data_gnt_o[m]),
            .data_gnt_i     (gnt_mb[m]),
            .data_req_o     (req_mb[m])
        );

        // Transpose between master and bank orientation
        for (genvar b = 0; b < lic_pkg::N_BANK; b++)
        begin : g_xpose
            assign req_bm[b][m] = req_mb[m][b];
            assign gnt_mb[m][b] = gnt_bm[b][m];
        end
    end

    //////////////////////////////
    // Bank side
    //////////////////////////////

    for (genvar b = 0; b < lic_pkg::N_BANK; b++)
    begin : g_bank
        rr_arb_tree u_rr_arb_tree
        (
            .clk        (clk),
            .rst_i      (rst_i),
            .req_i      (req_bm[b]),
            .data_i     (data_i),
            .gnt_o      (gnt_bm[b]),
            .bank_en_o  (bank_en[b]),
            .bank_req_o (bank_req[b]),
            .winner_o   (winner[b])
        );

        tcdm_bank u_tcdm_bank
        (
            .clk     (clk),
            .en_i    (bank_en[b]),
            .req_i   (bank_req[b]),
            .rdata_o (bank_rdata[b])
        );

        // Only granted reads produce a response
        assign rd_gnt[b] = bank_en[b] && (bank_req[b].op == lic_pkg::OP_READ);
    end

    // Read data goes back to whichever master the bank served
    resp_router u_resp_router
    (
        .clk      (clk),
        .rst_i    (rst_i),
        .rd_gnt_i (rd_gnt),
        .winner_i (winner),
        .rdata_i  (bank_rdata),
        .resp_o   (resp_o)
    );

endmodule

`default_nettype wire

// File: src/resp_router.sv
// Response router that steers each bank's read data back to the master it served

`default_nettype none

module resp_router
(
    input  logic                                                clk,
    input  logic                                                rst_i,

    // Granted read per bank, sampled at the access edge
    input  logic [lic_pkg::N_BANK-1:0]                          rd_gnt_i,
    input  logic [lic_pkg::N_BANK-1:0][lic_pkg::MST_W-1:0]      winner_i,

    // Bank read data, one cycle after the access
    input  logic [lic_pkg::N_BANK-1:0][lic_pkg::DATA_W-1:0]     rdata_i,

    // Responses toward the masters
    output lic_pkg::lic_resp_t [lic_pkg::N_MASTER-1:0]          resp_o
);

    // Read in flight on each bank
    logic [lic_pkg::N_BANK-1:0]                     rd_pend_q;
    // Master that owns the read in flight
    logic [lic_pkg::N_BANK-1:0][lic_pkg::MST_W-1:0] winner_q;

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            rd_pend_q <= '0;
        end
        else
        begin
            rd_pend_q <= rd_gnt_i;
        end
    end

    always_ff @(posedge clk)
    begin
        winner_q <= winner_i;
    end

    //////////////////////////////
    // Gather per master
    //////////////////////////////

    always_comb
    begin
        for (int m = 0; m < lic_pkg::N_MASTER; m++)
        begin
            resp_o[m] = '0;
            // A master wins at most one bank per cycle, so at most one hit
            for (int b = 0; b < lic_pkg::N_BANK; b++)
            begin
                if (rd_pend_q[b] && (int'(winner_q[b]) == m))
                begin
                    resp_o[m].valid = 1'b1;
                    resp_o[m].rdata = rdata_i[b];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/tcdm_bank.sv
// Single-port synchronous memory bank with one cycle of read latency

`default_nettype none

module tcdm_bank
(
    input  logic                            clk,

    // Access strobe from the arbiter
    input  logic                            en_i,
    input  lic_pkg::lic_bank_req_t          req_i,

    // Read data, valid the cycle after a read
    output logic [lic_pkg::DATA_W-1:0]      rdata_o
);

    // Storage array, contents undefined until written
    logic [lic_pkg::DATA_W-1:0] mem_q [lic_pkg::BANK_WORDS];

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (en_i && (req_i.op == lic_pkg::OP_WRITE))
        begin
            mem_q[req_i.addr] <= req_i.wdata;
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        // Output register keeps the last read word between reads
        if (en_i && (req_i.op == lic_pkg::OP_READ))
        begin
            rdata_o <= mem_q[req_i.addr];
        end
    end

endmodule

`default_nettype wire

// File: src/rr_arb_tree.sv
// Per-bank round-robin arbiter that grants one master and forwards its request

`default_nettype none

module rr_arb_tree
(
    input  logic                                        clk,
    input  logic                                        rst_i,

    // Competing masters for this bank
    input  logic [lic_pkg::N_MASTER-1:0]                req_i,
    input  lic_pkg::lic_req_t [lic_pkg::N_MASTER-1:0]   data_i,
    output logic [lic_pkg::N_MASTER-1:0]                gnt_o,

    // Toward the bank
    output logic                                        bank_en_o,
    output lic_pkg::lic_bank_req_t                      bank_req_o,
    output logic [lic_pkg::MST_W-1:0]                   winner_o
);

    // Master holding highest priority this cycle
    logic [lic_pkg::MST_W-1:0] ptr_q;
    logic [lic_pkg::MST_W-1:0] ptr_nxt;
    // Selected master and whether anyone was selected
    logic [lic_pkg::MST_W-1:0] winner;
    logic                      gnt_found;

    //////////////////////////////
    // Winner selection
    //////////////////////////////

    always_comb
    begin : pick_winner
        int unsigned idx;
        gnt_found = 1'b0;
        winner    = '0;
        // Scan masters starting at the pointer, wrapping around
        for (int i = 0; i < lic_pkg::N_MASTER; i++)
        begin
            idx = (int'(ptr_q) + i) % lic_pkg::N_MASTER;
            if (!gnt_found && req_i[idx])
            begin
                gnt_found = 1'b1;
                winner    = idx[lic_pkg::MST_W-1:0];
            end
        end
    end

    always_comb
    begin
        // One-hot grant, or nothing at all
        gnt_o = '0;
        if (gnt_found)
        begin
            gnt_o[winner] = 1'b1;
        end
    end

    // Bank select bits are dropped, the bank already knows who it is
    assign bank_req_o.addr  = data_i[winner].addr[lic_pkg::ADDR_W-1:lic_pkg::BANK_SEL_W];
    assign bank_req_o.op    = data_i[winner].op;
    assign bank_req_o.wdata = data_i[winner].wdata;
    assign bank_en_o        = gnt_found;
    assign winner_o         = winner;

    //////////////////////////////
    // Priority pointer
    //////////////////////////////

    // Next priority goes to the master after the winner
    assign ptr_nxt = (int'(winner) == lic_pkg::N_MASTER - 1) ? '0 : winner + 1'b1;

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            ptr_q <= '0;
        end
        else if (gnt_found)
        begin
            ptr_q <= ptr_nxt;
        end
    end

endmodule

`default_nettype wire

// File: src/addr_dec_req.sv
// Per-master address decoder: fans one request out to a bank and routes its grant back

`default_nettype none

module addr_dec_req
(
    // Master side
    input  logic                            data_req_i,
    input  logic [lic_pkg::BANK_SEL_W-1:0]  routing_addr_i,
    output logic                            data_gnt_o,

    // Arbiter side, one bit per bank
    input  logic [lic_pkg::N_BANK-1:0]      data_gnt_i,
    output logic [lic_pkg::N_BANK-1:0]      data_req_o
);

    generate
        if (lic_pkg::N_BANK == 1)
        begin : g_single_bank
            // Only one bank, nothing to decode
            assign data_req_o[0] = data_req_i;
            assign data_gnt_o    = data_gnt_i[0];
        end
        else
        begin : g_multi_bank
            always_comb
            begin
                // All banks idle unless selected
                data_req_o = '0;
                // Raise the request only toward the addressed bank
                data_req_o[routing_addr_i] = data_req_i;
                // Grant comes from the same bank, same cycle
                data_gnt_o = data_gnt_i[routing_addr_i];
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: src/lic_pkg.sv
// Logarithmic interconnect package with sizes, opcodes and request/response payloads

`default_nettype none

package lic_pkg;

    //////////////////////////////
    // Topology
    //////////////////////////////

    // Master cores on the request side
    localparam int N_MASTER = 4;
    // Single-port banks on the memory side
    localparam int N_BANK = 4;
    // Width of a master index
    localparam int MST_W = 2;
    // Width of a bank index, taken from the low word-address bits
    localparam int BANK_SEL_W = 2;

    //////////////////////////////
    // Address and data
    //////////////////////////////

    // Word address inside one bank
    localparam int BANK_ADDR_W = 8;
    // Depth of one bank in words
    localparam int BANK_WORDS = 2 ** BANK_ADDR_W;
    // Word address as seen by a master: in-bank part above the bank select
    localparam int ADDR_W = BANK_ADDR_W + BANK_SEL_W;
    // Data word
    localparam int DATA_W = 32;

    //////////////////////////////
    // Payload types
    //////////////////////////////

    // Access type carried with every request
    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } lic_op_e;

    // Request as issued by a master core
    typedef struct packed
    {
        logic [ADDR_W-1:0] addr;
        lic_op_e           op;
        logic [DATA_W-1:0] wdata;
    } lic_req_t;

    // Request as seen by a bank, bank select already stripped
    typedef struct packed
    {
        logic [BANK_ADDR_W-1:0] addr;
        lic_op_e                op;
        logic [DATA_W-1:0]      wdata;
    } lic_bank_req_t;

    // Read response back to a master, valid for one cycle
    typedef struct packed
    {
        logic              valid;
        logic [DATA_W-1:0] rdata;
    } lic_resp_t;

endpackage

`default_nettype wire
